// ==== filelist.f ====
hdl/noc_config_pkg.sv
hdl/noc_flit_pkg.sv
hdl/noc_fifo.sv
hdl/noc_flit_if_fifo.sv
hdl/noc_vc_arbiter.sv
hdl/noc_apb_regs.sv
hdl/noc_input_port.sv
verif/noc_input_port_tb.sv

// ==== hdl/noc_apb_regs.sv ====
`timescale 1ns/1ps

module noc_apb_regs
  import noc_config_pkg::*;
(
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [NOC_APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic [NOC_APB_DATA_WIDTH-1:0] i_pwdata,
  input  logic [NOC_STATUS_WIDTH-1:0]   i_status,
  input  logic                          i_flit_sent,
  output logic [NOC_APB_DATA_WIDTH-1:0] o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr,
  output logic                          o_clear
);

  logic                          access;
  logic                          hit_ctrl;
  logic                          hit_status;
  logic                          hit_count;
  logic                          clear_req;
  logic [NOC_APB_DATA_WIDTH-1:0] flit_count;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  assign access     = i_psel & i_penable;  // Access phase.
  assign hit_ctrl   = (i_paddr == NOC_ADDR_CTRL);
  assign hit_status = (i_paddr == NOC_ADDR_STATUS);
  assign hit_count  = (i_paddr == NOC_ADDR_COUNT);

  assign o_pready  = 1'b1;  // No wait states.
  assign o_pslverr = access & ~(hit_ctrl | hit_status | hit_count);
  assign clear_req = access & i_pwrite & hit_ctrl & i_pwdata[0];

  always_comb begin
    o_prdata = '0;
    if (hit_status) begin
      o_prdata = NOC_APB_DATA_WIDTH'(i_status);
    end else if (hit_count) begin
      o_prdata = flit_count;
    end
  end

  ////////////////////////////////////////
  // Clear pulse and flit counter
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_clear <= 1'b0;
    end else begin
      o_clear <= clear_req;  // High for one cycle.
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      flit_count <= '0;
    end else if (o_clear) begin
      flit_count <= '0;
    end else if (i_flit_sent) begin
      flit_count <= flit_count + 1'b1;
    end
  end

endmodule

// ==== hdl/noc_config_pkg.sv ====
package noc_config_pkg;

  ////////////////////////////////////////
  // Buffer geometry
  ////////////////////////////////////////
  localparam int NOC_CHANNELS    = 2;                             // Virtual channels.
  localparam int NOC_FIFO_DEPTH  = 8;
  localparam int NOC_THRESHOLD   = 6;                             // Almost-full level.
  localparam int NOC_PTR_WIDTH   = $clog2(NOC_FIFO_DEPTH);
  localparam int NOC_COUNT_WIDTH = $clog2(NOC_FIFO_DEPTH + 1);

  // Local empty, local full, internal empty, internal full.
  localparam int NOC_STATUS_WIDTH = 2 * NOC_CHANNELS + 2;

  ////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////
  localparam int NOC_APB_ADDR_WIDTH = 8;
  localparam int NOC_APB_DATA_WIDTH = 32;

  localparam logic [NOC_APB_ADDR_WIDTH-1:0] NOC_ADDR_CTRL   = 8'h00;
  localparam logic [NOC_APB_ADDR_WIDTH-1:0] NOC_ADDR_STATUS = 8'h04;
  localparam logic [NOC_APB_ADDR_WIDTH-1:0] NOC_ADDR_COUNT  = 8'h08;

  typedef enum logic {
    NOC_LOCAL_PORT,
    NOC_INTERNAL_PORT
  } noc_port_type_e;

endpackage

// ==== hdl/noc_fifo.sv ====
`timescale 1ns/1ps

module noc_fifo
  import noc_config_pkg::*;
#(
  parameter type T = logic
)(
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_clear,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_empty,
  output logic o_almost_full,
  output logic o_full
);

  T                           mem [NOC_FIFO_DEPTH];
  logic [NOC_PTR_WIDTH-1:0]   wr_ptr;
  logic [NOC_PTR_WIDTH-1:0]   rd_ptr;
  logic [NOC_COUNT_WIDTH-1:0] count;
  logic                       push_en;
  logic                       pop_en;

  assign push_en = i_push & ~o_full;  // Writes into a full FIFO are ignored.
  assign pop_en  = i_pop & ~o_empty;

  ////////////////////////////////////////
  // Flags and show-ahead head
  ////////////////////////////////////////
  assign o_empty       = (count == '0);
  assign o_full        = (count == NOC_COUNT_WIDTH'(NOC_FIFO_DEPTH));
  assign o_almost_full = (count >= NOC_COUNT_WIDTH'(NOC_THRESHOLD));
  assign o_data        = mem[rd_ptr];  // Head is valid while not empty.

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == NOC_PTR_WIDTH'(NOC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == NOC_PTR_WIDTH'(NOC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

endmodule

// ==== hdl/noc_flit_if_fifo.sv ====
`timescale 1ns/1ps

module noc_flit_if_fifo
  import noc_config_pkg::*,
         noc_flit_pkg::*;
#(
  parameter  noc_port_type_e PORT_TYPE = NOC_LOCAL_PORT,
  localparam int             FLITS     = (PORT_TYPE == NOC_LOCAL_PORT) ? NOC_CHANNELS : 1
)(
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic                    i_clear,
  input  logic [NOC_CHANNELS-1:0] i_valid,
  input  noc_flit_t [FLITS-1:0]   i_flit,
  output logic [NOC_CHANNELS-1:0] o_ready,
  output logic [NOC_CHANNELS-1:0] o_vc_available,
  output logic [NOC_CHANNELS-1:0] o_valid,
  output noc_flit_t [FLITS-1:0]   o_flit,
  output logic [FLITS-1:0]        o_empty,
  output logic [FLITS-1:0]        o_almost_full,
  output logic [FLITS-1:0]        o_full,
  input  logic [NOC_CHANNELS-1:0] i_ready
);

  if (PORT_TYPE == NOC_LOCAL_PORT) begin : g_local_port
    ////////////////////////////////////////
    // One FIFO per virtual channel
    ////////////////////////////////////////
    for (genvar v = 0; v < NOC_CHANNELS; v++) begin : g_vc
      assign o_ready[v]        = ~o_full[v];
      assign o_vc_available[v] = ~o_almost_full[v];
      assign o_valid[v]        = ~o_empty[v];

      noc_fifo #(
        .T (noc_flit_t)
      ) fifo_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_clear       (i_clear),
        .i_push        (i_valid[v]),
        .i_data        (i_flit[v]),
        .i_pop         (i_ready[v]),
        .o_data        (o_flit[v]),
        .o_empty       (o_empty[v]),
        .o_almost_full (o_almost_full[v]),
        .o_full        (o_full[v])
      );
    end
  end else begin : g_internal_port
    ////////////////////////////////////////
    // Shared FIFO with a VC tag per entry
    ////////////////////////////////////////
    noc_vc_flit_t push_data;
    noc_vc_flit_t pop_data;
    logic         push;
    logic         pop;

    // All VCs share the space, so they see the same flags.
    assign o_ready        = {NOC_CHANNELS{~o_full[0]}};
    assign o_vc_available = {NOC_CHANNELS{~o_almost_full[0]}};
    assign o_valid        = o_empty[0] ? '0 : pop_data.vc;
    assign o_flit[0]      = pop_data.flit;

    assign push           = |i_valid;
    assign push_data.vc   = i_valid;  // Valid vector is already one-hot.
    assign push_data.flit = i_flit[0];
    assign pop            = |(o_valid & i_ready);

    noc_fifo #(
      .T (noc_vc_flit_t)
    ) fifo_i (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_clear       (i_clear),
      .i_push        (push),
      .i_data        (push_data),
      .i_pop         (pop),
      .o_data        (pop_data),
      .o_empty       (o_empty[0]),
      .o_almost_full (o_almost_full[0]),
      .o_full        (o_full[0])
    );
  end

endmodule

// ==== hdl/noc_flit_pkg.sv ====
package noc_flit_pkg;

  import noc_config_pkg::*;

  ////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////
  localparam int NOC_DATA_WIDTH = 32;
  localparam int NOC_DEST_WIDTH = 4;

  typedef struct packed {
    logic                      head;       // First flit of a packet.
    logic                      tail;       // Last flit, releases the VC lock.
    logic [NOC_DEST_WIDTH-1:0] dest;
    logic [NOC_DATA_WIDTH-1:0] data;
  } noc_flit_t;

  // Entry of the shared FIFO, flit plus the VC it came from.
  typedef struct packed {
    logic [NOC_CHANNELS-1:0] vc;         // One-hot.
    noc_flit_t               flit;
  } noc_vc_flit_t;

endpackage

// ==== hdl/noc_input_port.sv ====
`timescale 1ns/1ps

module noc_input_port
  import noc_config_pkg::*,
         noc_flit_pkg::*;
(
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [NOC_APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic [NOC_APB_DATA_WIDTH-1:0] i_pwdata,
  output logic [NOC_APB_DATA_WIDTH-1:0] o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr,
  input  logic [NOC_CHANNELS-1:0]       i_flit_valid,
  input  noc_flit_t [NOC_CHANNELS-1:0]  i_flit,
  output logic [NOC_CHANNELS-1:0]       o_flit_ready,
  output logic [NOC_CHANNELS-1:0]       o_vc_available,
  output logic [NOC_CHANNELS-1:0]       o_flit_valid,
  output noc_flit_t                     o_flit,
  input  logic [NOC_CHANNELS-1:0]       i_flit_ready
);

  logic                         clear;
  logic                         flit_sent;
  logic [NOC_CHANNELS-1:0]      loc_valid;
  noc_flit_t [NOC_CHANNELS-1:0] loc_flit;
  logic [NOC_CHANNELS-1:0]      loc_pop;
  logic [NOC_CHANNELS-1:0]      loc_empty;
  logic [NOC_CHANNELS-1:0]      loc_full;
  logic [NOC_CHANNELS-1:0]      arb_valid;
  noc_flit_t                    arb_flit;
  logic [NOC_CHANNELS-1:0]      int_ready;
  logic [0:0]                   int_empty;
  logic [0:0]                   int_full;

  assign flit_sent = |(o_flit_valid & i_flit_ready);

  noc_flit_if_fifo #(
    .PORT_TYPE (NOC_LOCAL_PORT)
  ) local_fifo_i (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_clear        (clear),
    .i_valid        (i_flit_valid),
    .i_flit         (i_flit),
    .o_ready        (o_flit_ready),
    .o_vc_available (o_vc_available),
    .o_valid        (loc_valid),
    .o_flit         (loc_flit),
    .o_empty        (loc_empty),
    .o_almost_full  (),
    .o_full         (loc_full),
    .i_ready        (loc_pop)
  );

  noc_vc_arbiter arbiter_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_clear     (clear),
    .i_req       (loc_valid),
    .i_flit      (loc_flit),
    .i_out_ready (int_ready),
    .o_pop       (loc_pop),
    .o_valid     (arb_valid),
    .o_flit      (arb_flit)
  );

  noc_flit_if_fifo #(
    .PORT_TYPE (NOC_INTERNAL_PORT)
  ) internal_fifo_i (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_clear        (clear),
    .i_valid        (arb_valid),
    .i_flit         (arb_flit),
    .o_ready        (int_ready),
    .o_vc_available (),
    .o_valid        (o_flit_valid),
    .o_flit         (o_flit),
    .o_empty        (int_empty),
    .o_almost_full  (),
    .o_full         (int_full),
    .i_ready        (i_flit_ready)
  );

  noc_apb_regs regs_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .i_status    ({int_full, int_empty, loc_full, loc_empty}),
    .i_flit_sent (flit_sent),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_clear     (clear)
  );

endmodule

// ==== hdl/noc_vc_arbiter.sv ====
`timescale 1ns/1ps

module noc_vc_arbiter
  import noc_config_pkg::*,
         noc_flit_pkg::*;
(
  input  logic                         clk,
  input  logic                         i_arst_n,
  input  logic                         i_clear,
  input  logic [NOC_CHANNELS-1:0]      i_req,
  input  noc_flit_t [NOC_CHANNELS-1:0] i_flit,
  input  logic [NOC_CHANNELS-1:0]      i_out_ready,
  output logic [NOC_CHANNELS-1:0]      o_pop,
  output logic [NOC_CHANNELS-1:0]      o_valid,
  output noc_flit_t                    o_flit
);

  logic [NOC_CHANNELS-1:0] last_grant;  // One-hot, last VC that moved a flit.
  logic [NOC_CHANNELS-1:0] lock_grant;
  logic                    locked;      // Inside a packet.
  logic [NOC_CHANNELS-1:0] rr_grant;
  logic [NOC_CHANNELS-1:0] grant;
  logic                    move;

  ////////////////////////////////////////
  // Round-robin pick after last winner
  ////////////////////////////////////////
  always_comb begin : rr_select
    int   last_idx;
    int   idx;
    logic found;
    last_idx = 0;
    found    = 1'b0;
    rr_grant = '0;
    for (int i = 0; i < NOC_CHANNELS; i++) begin
      if (last_grant[i]) begin
        last_idx = i;
      end
    end
    for (int k = 1; k <= NOC_CHANNELS; k++) begin
      idx = (last_idx + k) % NOC_CHANNELS;
      if (!found && i_req[idx]) begin
        rr_grant[idx] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // A locked VC keeps the lane even while its FIFO runs dry.
  assign grant   = locked ? lock_grant : rr_grant;
  assign o_valid = grant & i_req;
  assign o_pop   = grant & i_req & i_out_ready;
  assign move    = |o_pop;

  always_comb begin
    o_flit = '0;
    for (int i = 0; i < NOC_CHANNELS; i++) begin
      if (grant[i]) begin
        o_flit = i_flit[i];
      end
    end
  end

  ////////////////////////////////////////
  // Packet lock
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      last_grant <= NOC_CHANNELS'(1) << (NOC_CHANNELS - 1);  // VC 0 wins first.
      lock_grant <= '0;
      locked     <= 1'b0;
    end else if (i_clear) begin
      last_grant <= NOC_CHANNELS'(1) << (NOC_CHANNELS - 1);
      lock_grant <= '0;
      locked     <= 1'b0;
    end else if (move) begin
      last_grant <= grant;
      lock_grant <= grant;
      locked     <= ~o_flit.tail;  // Tail releases the lane.
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the input port testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module noc_input_port_tb -o noc_input_port_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/noc_input_port_sim > sim.log 2>&1 \
  || { echo "Simulation did not complete, see sim.log"; exit 1; }

grep -q "Finished with no errors" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

// ==== verif/noc_input_port_tb.sv ====
`timescale 1ns/1ps

module noc_input_port_tb
  import noc_config_pkg::*,
         noc_flit_pkg::*;
();

  localparam int TOTAL_FLITS = 64;
  localparam int WATCHDOG    = TOTAL_FLITS * 40 + 2000;                // Cycles.

  logic                          clk;
  logic                          arst_n;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [NOC_APB_ADDR_WIDTH-1:0] paddr;
  logic [NOC_APB_DATA_WIDTH-1:0] pwdata;
  logic [NOC_APB_DATA_WIDTH-1:0] prdata;
  logic                          pready;
  logic                          pslverr;
  logic [NOC_CHANNELS-1:0]       flit_valid_in;
  noc_flit_t [NOC_CHANNELS-1:0]  flit_in;
  logic [NOC_CHANNELS-1:0]       flit_ready_out;
  logic [NOC_CHANNELS-1:0]       vc_available;
  logic [NOC_CHANNELS-1:0]       flit_valid_out;
  noc_flit_t                     flit_out;
  logic [NOC_CHANNELS-1:0]       flit_ready_in;

  logic [31:0] lfsr = 32'hfcf6;
  noc_flit_t   exp_q0[$];
  noc_flit_t   exp_q1[$];
  int          lat_q[$];                                              // Accept cycles, VC 0.
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          in_total = 0;
  int          out_total = 0;
  bit          ref_locked = 0;
  int          ref_lock_vc = 0;
  bit          check_latency = 0;
  bit          rand_ready = 0;

  noc_input_port dut_i (
    .clk (clk), .i_arst_n (arst_n),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata),
    .o_prdata (prdata), .o_pready (pready), .o_pslverr (pslverr),
    .i_flit_valid (flit_valid_in), .i_flit (flit_in),
    .o_flit_ready (flit_ready_out), .o_vc_available (vc_available),
    .o_flit_valid (flit_valid_out), .o_flit (flit_out),
    .i_flit_ready (flit_ready_in)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Next flit expected on a VC, following the packet lock.
  function automatic noc_flit_t predict_flit(input int vc);
    noc_flit_t f;
    if (ref_locked && vc != ref_lock_vc) begin
      $display("Packet interleaved at %0t: VC %0d sent while VC %0d held the lane",
               $time, vc, ref_lock_vc);
      errors++;
    end
    f           = (vc == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
    ref_locked  = !f.tail;
    ref_lock_vc = vc;
    return f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Monitors and comparator
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (arst_n) begin
      for (int v = 0; v < NOC_CHANNELS; v++) begin
        if (flit_valid_in[v] && flit_ready_out[v]) begin
          if (v == 0) exp_q0.push_back(flit_in[v]);
          else exp_q1.push_back(flit_in[v]);
          if (v == 0) lat_q.push_back(cycle);
          in_total++;
        end
      end
    end
  end

  always @(posedge clk) begin
    noc_flit_t exp_flit;
    int        qsize;
    int        acc;
    if (arst_n && |(flit_valid_out & flit_ready_in)) begin
      out_total++;
      if ($countones(flit_valid_out) != 1) begin
        $display("Output VC tag at %0t is not one-hot: %b", $time, flit_valid_out);
        errors++;
      end
      for (int v = 0; v < NOC_CHANNELS; v++) begin
        if (flit_valid_out[v] && flit_ready_in[v]) begin
          qsize = (v == 0) ? exp_q0.size() : exp_q1.size();
          if (qsize == 0) begin
            $display("Unexpected flit at %0t on VC %0d", $time, v);
            errors++;
          end else begin
            exp_flit = predict_flit(v);
            check_value($sformatf("o_flit (VC %0d)", v), 64'(exp_flit), 64'(flit_out));
          end
          if (v == 0 && lat_q.size() > 0) begin
            acc = lat_q.pop_front();
            if (check_latency) check_value("flit latency", 64'(2), 64'(cycle - acc));
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rand_ready) flit_ready_in <= NOC_CHANNELS'(rand_bits(NOC_CHANNELS));
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped moving flits", WATCHDOG);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_value("o_pready", 1, pready);                                // No wait states.
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic send_flit(input int vc, input noc_flit_t f);
    flit_in[vc]       <= f;
    flit_valid_in[vc] <= 1'b1;
    @(negedge clk);
    while (!flit_ready_out[vc]) @(negedge clk);
    @(posedge clk);
    flit_valid_in[vc] <= 1'b0;
  endtask

  task automatic send_packet(input int vc, input int len, input bit gaps);
    noc_flit_t   f;
    logic [31:0] r;
    @(posedge clk);
    for (int i = 0; i < len; i++) begin
      r      = rand_bits(NOC_DEST_WIDTH);
      f.head = (i == 0);
      f.tail = (i == len - 1);
      f.dest = r[3:0];
      f.data = rand_bits(32);
      send_flit(vc, f);
      if (gaps) begin
        r = rand_bits(2);
        repeat (r) @(posedge clk);
      end
    end
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("Test %s done, %0d errors", name, errors - err_before);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic        err;
    int          e0;
    noc_flit_t   f;
    psel          = 0;
    penable       = 0;
    pwrite        = 0;
    paddr         = '0;
    pwdata        = '0;
    flit_valid_in = '0;
    flit_in       = '0;
    flit_ready_in = '1;
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    e0 = errors;                                                      // After reset.
    @(negedge clk);
    check_value("o_flit_valid", 0, flit_valid_out);
    check_value("o_flit_ready", 64'(2'b11), flit_ready_out);
    apb_access(0, NOC_ADDR_STATUS, 0, rd, err);
    check_value("STATUS", 64'h13, rd);
    apb_access(0, NOC_ADDR_COUNT, 0, rd, err);
    check_value("COUNT", 0, rd);
    end_test("reset", e0);

    e0 = errors;
    check_latency = 1;
    send_packet(0, 10, 0);
    wait_drain();
    check_latency = 0;
    end_test("steady flow", e0);

    e0 = errors;
    rand_ready = 1;
    fork
      for (int p = 0; p < 4; p++) send_packet(0, 1 + int'(rand_bits(2)), 1);
      for (int p = 0; p < 4; p++) send_packet(1, 1 + int'(rand_bits(2)), 1);
    join
    wait_drain();
    rand_ready = 0;
    flit_ready_in <= '1;
    wait_drain();
    end_test("two VCs", e0);

    e0 = errors;
    @(posedge clk);
    flit_ready_in <= '0;
    for (int k = 0; k < 16; k++) begin
      @(negedge clk);
      check_value("o_flit_ready[0]", 1, flit_ready_out[0]);
      check_value("o_vc_available[0]", (k < 14) ? 1 : 0, vc_available[0]);
      f.head = (k == 0);
      f.tail = (k == 15);
      f.dest = 4'(k);
      f.data = rand_bits(32);
      @(posedge clk);
      send_flit(0, f);
      repeat (2) @(posedge clk);
    end
    @(negedge clk);
    check_value("o_flit_ready[0]", 0, flit_ready_out[0]);
    check_value("o_vc_available[0]", 0, vc_available[0]);
    flit_ready_in <= '1;
    wait_drain();
    end_test("stalled output", e0);

    e0 = errors;
    apb_access(0, NOC_ADDR_COUNT, 0, rd, err);
    check_value("COUNT", 64'(in_total), rd);
    check_value("o_pslverr", 0, err);
    check_value("flits out", 64'(in_total), 64'(out_total));
    @(posedge clk);
    flit_ready_in <= '0;
    send_packet(1, 3, 0);
    repeat (3) @(posedge clk);
    apb_access(1, NOC_ADDR_CTRL, 32'h1, rd, err);
    exp_q0.delete();
    exp_q1.delete();
    lat_q.delete();
    ref_locked = 0;
    apb_access(0, NOC_ADDR_STATUS, 0, rd, err);
    check_value("STATUS", 64'h13, rd);
    apb_access(0, NOC_ADDR_COUNT, 0, rd, err);
    check_value("COUNT", 0, rd);
    apb_access(0, 8'h0c, 0, rd, err);
    check_value("o_pslverr", 1, err);
    flit_ready_in <= '1;
    repeat (4) @(posedge clk);
    end_test("registers", e0);

    $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
